//--- rtl/audio_sample_pkg.sv
package audio_sample_pkg;

	////////////////////
	// Sample widths
	////////////////////

	// Width of one PCM sample as produced by the sound card and the synth
	parameter int sample_width = 16;

	////////////////////
	// Sample types
	////////////////////

	// One signed PCM sample
	typedef logic signed [sample_width-1:0] pcm_sample_t;

	// Mixer accumulator, one guard bit above a PCM sample
	typedef logic signed [sample_width:0] wide_sample_t;

	// Left and right channel of one sample period
	typedef struct packed {
		pcm_sample_t left;
		pcm_sample_t right;
	} stereo_sample_t;

endpackage

//--- rtl/audio_ctrl_pkg.sv
package audio_ctrl_pkg;

	////////////////////
	// Compressor mode
	////////////////////

	// Code 3 is unused and behaves like COMP_STRONG
	typedef enum logic [1:0] {
		COMP_OFF    = 2'd0,
		COMP_MILD   = 2'd1,
		COMP_STRONG = 2'd2
	} comp_mode_t;

	////////////////////
	// Mixer settings
	////////////////////

	// Speaker level as a left shift, 0 is quietest
	typedef logic [1:0] speaker_vol_t;

	// Static settings, changed only while no sample is in flight
	typedef struct packed {
		speaker_vol_t speaker_vol;
		logic         synth_mute;
		comp_mode_t   comp_mode;
	} mix_ctrl_t;

endpackage

//--- rtl/sample_settle_filter.sv
`timescale 1ns/1ps

module sample_settle_filter
	import audio_sample_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           sample_tick,
	input  stereo_sample_t sb_sample,
	output stereo_sample_t settled,
	output logic           settled_valid
);

	// Two most recent readings of the sound card output
	stereo_sample_t hist_new;
	stereo_sample_t hist_prev;

	// Last reading that was seen twice in a row
	stereo_sample_t held;

	////////////////////
	// History and hold
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hist_new  <= '0;
			hist_prev <= '0;
			held      <= '0;
		end else if (sample_tick) begin
			hist_new  <= sb_sample;
			hist_prev <= hist_new;
			// Compare before the shift takes effect
			if (hist_new == hist_prev) begin
				held <= hist_prev;
			end
		end
	end

	////////////////////
	// Output strobe
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			settled_valid <= 1'b0;
		end else begin
			settled_valid <= sample_tick;
		end
	end

	// Held value is already updated when the strobe goes high
	assign settled = held;

endmodule

//--- rtl/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer
	import audio_sample_pkg::*;
	import audio_ctrl_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	input  stereo_sample_t settled,
	input  logic           settled_valid,
	input  logic           speaker,
	input  stereo_sample_t synth_sample,
	input  mix_ctrl_t      ctrl,
	output stereo_sample_t mixed,
	output logic           mixed_valid
);

	// Speaker contribution, the same on both channels
	wide_sample_t spk_term;

	stereo_sample_t mix_next;

	// Sum of three terms, saturated back to a PCM sample
	function automatic pcm_sample_t mix_channel(
		input pcm_sample_t  sb,
		input pcm_sample_t  synth,
		input wide_sample_t spk,
		input logic         mute
	);
		wide_sample_t sum;
		wide_sample_t synth_term;
		pcm_sample_t  result;

		synth_term = mute ? wide_sample_t'(0) : wide_sample_t'(synth);
		sum = wide_sample_t'(sb) + spk + synth_term;
		// Top two bits differ means the sum left the 16-bit range
		if (sum[sample_width] != sum[sample_width-1]) begin
			result = sum[sample_width] ? 16'sh8000 : 16'sh7fff;
		end else begin
			result = sum[sample_width-1:0];
		end
		return result;
	endfunction

	////////////////////
	// Mix and clamp
	////////////////////

	always_comb begin
		// Volume 0 gives 2048, volume 3 gives 16384
		spk_term = speaker ? (wide_sample_t'(1) <<< (11 + ctrl.speaker_vol)) : '0;
		mix_next.left  = mix_channel(settled.left, synth_sample.left, spk_term,
			ctrl.synth_mute);
		mix_next.right = mix_channel(settled.right, synth_sample.right, spk_term,
			ctrl.synth_mute);
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (settled_valid) begin
			mixed <= mix_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mixed_valid <= 1'b0;
		end else begin
			mixed_valid <= settled_valid;
		end
	end

endmodule

//--- rtl/dynamic_compressor.sv
`timescale 1ns/1ps

module dynamic_compressor
	import audio_sample_pkg::*;
	import audio_ctrl_pkg::*;
#(
	parameter int slope_f_mild   = 4,
	parameter int gain_a_mild    = 2,
	parameter int slope_f_strong = 8,
	parameter int gain_a_strong  = 4
) (
	input  logic           clk_sys,
	input  logic           reset,
	input  stereo_sample_t mixed,
	input  logic           mixed_valid,
	input  comp_mode_t     comp_mode,
	output stereo_sample_t out_sample,
	output logic           out_valid
);

	////////////////////
	// Knee points
	////////////////////

	// Knee point and offset where the gain segment meets the slope segment
	localparam logic [15:0] knee_x_mild =
		16'((32767 * (slope_f_mild - 1)) / (slope_f_mild * gain_a_mild - 1) + 1);
	localparam logic [15:0] knee_b_mild = 16'(knee_x_mild * gain_a_mild);

	localparam logic [15:0] knee_x_strong =
		16'((32767 * (slope_f_strong - 1)) / (slope_f_strong * gain_a_strong - 1) + 1);
	localparam logic [15:0] knee_b_strong = 16'(knee_x_strong * gain_a_strong);

	stereo_sample_t comp_next;

	// Piecewise curve on a magnitude, gain below the knee and slope above it
	function automatic logic [15:0] curve(
		input logic [15:0] v,
		input logic [15:0] knee_x,
		input logic [15:0] knee_b,
		input int          slope_f,
		input int          gain_a
	);
		logic [15:0] result;

		if (v < knee_x) begin
			result = 16'(v * gain_a);
		end else begin
			result = 16'((v - knee_x) / slope_f + knee_b);
		end
		return result;
	endfunction

	function automatic pcm_sample_t compress(
		input pcm_sample_t s,
		input comp_mode_t  mode
	);
		logic [15:0] mag;
		logic [15:0] shaped;
		pcm_sample_t result;

		// -32768 maps onto itself, which the curve handles as 32768
		mag = s[sample_width-1] ? 16'(~s + 16'd1) : 16'(s);
		if (mode == COMP_MILD) begin
			shaped = curve(mag, knee_x_mild, knee_b_mild, slope_f_mild, gain_a_mild);
		end else begin
			shaped = curve(mag, knee_x_strong, knee_b_strong, slope_f_strong,
				gain_a_strong);
		end
		if (mode == COMP_OFF) begin
			result = s;
		end else if (s[sample_width-1]) begin
			result = pcm_sample_t'(16'(~shaped + 16'd1));
		end else begin
			result = pcm_sample_t'(shaped);
		end
		return result;
	endfunction

	always_comb begin
		comp_next.left  = compress(mixed.left, comp_mode);
		comp_next.right = compress(mixed.right, comp_mode);
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (mixed_valid) begin
			out_sample <= comp_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= mixed_valid;
		end
	end

endmodule

//--- rtl/audio_path_top.sv
`timescale 1ns/1ps

module audio_path_top
	import audio_sample_pkg::*;
	import audio_ctrl_pkg::*;
#(
	// Slope and gain of the two compressor curves
	parameter int comp_f_mild   = 4,
	parameter int comp_a_mild   = 2,
	parameter int comp_f_strong = 8,
	parameter int comp_a_strong = 4
) (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           sample_tick,
	input  stereo_sample_t sb_sample,
	input  logic           speaker,
	input  stereo_sample_t synth_sample,
	input  mix_ctrl_t      ctrl,
	output stereo_sample_t out_sample,
	output logic           out_valid
);

	////////////////////
	// Stage wires
	////////////////////

	// Filter to mixer
	stereo_sample_t settled;
	logic           settled_valid;

	// Mixer to compressor
	stereo_sample_t mixed;
	logic           mixed_valid;

	////////////////////
	// Settling filter
	////////////////////

	sample_settle_filter u_settle (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.sample_tick   (sample_tick),
		.sb_sample     (sb_sample),
		.settled       (settled),
		.settled_valid (settled_valid)
	);

	////////////////////
	// Mixer
	////////////////////

	audio_mixer u_mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.settled       (settled),
		.settled_valid (settled_valid),
		.speaker       (speaker),
		.synth_sample  (synth_sample),
		.ctrl          (ctrl),
		.mixed         (mixed),
		.mixed_valid   (mixed_valid)
	);

	////////////////////
	// Compressor
	////////////////////

	// Three register stages in total, out_valid trails sample_tick by 3
	dynamic_compressor #(
		.slope_f_mild   (comp_f_mild),
		.gain_a_mild    (comp_a_mild),
		.slope_f_strong (comp_f_strong),
		.gain_a_strong  (comp_a_strong)
	) u_comp (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mixed       (mixed),
		.mixed_valid (mixed_valid),
		.comp_mode   (ctrl.comp_mode),
		.out_sample  (out_sample),
		.out_valid   (out_valid)
	);

endmodule

//--- sim/tb_audio_path.sv
`timescale 1ns/1ps

module tb_audio_path
	import audio_sample_pkg::*;
	import audio_ctrl_pkg::*;
;

	localparam int comp_f_mild   = 4;
	localparam int comp_a_mild   = 2;
	localparam int comp_f_strong = 8;
	localparam int comp_a_strong = 4;

	// About 1500 ticks at up to 8 cycles apart, with margin
	localparam int max_cycles = 20000;

	logic           clk_sys = 1'b0;
	logic           reset;
	logic           sample_tick;
	stereo_sample_t sb_sample;
	logic           speaker;
	stereo_sample_t synth_sample;
	mix_ctrl_t      ctrl;
	stereo_sample_t out_sample;
	logic           out_valid;

	integer seed = 69390;
	int     cycle_count = 0;
	int     ticks_sent = 0;
	int     checks_done = 0;
	int     error_count = 0;

	// Expected results and the cycle their tick was sampled
	stereo_sample_t exp_q[$];
	int             cyc_q[$];

	// Model of the settling filter history
	stereo_sample_t m_new;
	stereo_sample_t m_prev;
	stereo_sample_t m_held;

	int edge_vals[$];

	always #4 clk_sys = ~clk_sys;

	audio_path_top #(
		.comp_f_mild   (comp_f_mild),
		.comp_a_mild   (comp_a_mild),
		.comp_f_strong (comp_f_strong),
		.comp_a_strong (comp_a_strong)
	) uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_tick  (sample_tick),
		.sb_sample    (sb_sample),
		.speaker      (speaker),
		.synth_sample (synth_sample),
		.ctrl         (ctrl),
		.out_sample   (out_sample),
		.out_valid    (out_valid)
	);

	////////////////////
	// Reference model
	////////////////////

	function automatic int knee_point(input int f, input int a);
		return (32767 * (f - 1)) / (f * a - 1) + 1;
	endfunction

	// Three terms summed in 17 bits, then saturated to 16
	function automatic pcm_sample_t mix_ref(
		input pcm_sample_t sb,
		input pcm_sample_t syn,
		input logic        spk,
		input logic [1:0]  vol,
		input logic        mute
	);
		int                 total;
		logic signed [16:0] sum17;
		pcm_sample_t        r;

		total = int'(sb);
		if (spk) begin
			total = total + (1 << (11 + vol));
		end
		if (!mute) begin
			total = total + int'(syn);
		end
		sum17 = total[16:0];
		if (sum17 > 32767) begin
			r = 16'sh7fff;
		end else if (sum17 < -32768) begin
			r = 16'sh8000;
		end else begin
			r = sum17[15:0];
		end
		return r;
	endfunction

	function automatic pcm_sample_t comp_ref(input pcm_sample_t s, input logic [1:0] mode);
		int          f;
		int          a;
		int          x;
		int          b;
		int          v;
		int          y;
		pcm_sample_t r;

		if (mode == 2'd1) begin
			f = comp_f_mild;
			a = comp_a_mild;
		end else begin
			f = comp_f_strong;
			a = comp_a_strong;
		end
		x = knee_point(f, a) & 32'hffff;
		b = (x * a) & 32'hffff;
		v = (s < 0) ? -int'(s) : int'(s);
		if (v < x) begin
			y = (v * a) & 32'hffff;
		end else begin
			y = ((v - x) / f + b) & 32'hffff;
		end
		if (s < 0) begin
			y = (-y) & 32'hffff;
		end
		r = (mode == 2'd0) ? s : pcm_sample_t'(y[15:0]);
		return r;
	endfunction

	function automatic stereo_sample_t expected_out(
		input stereo_sample_t held,
		input logic           spk,
		input stereo_sample_t syn,
		input mix_ctrl_t      c
	);
		stereo_sample_t r;

		r.left  = comp_ref(mix_ref(held.left, syn.left, spk, c.speaker_vol, c.synth_mute),
			c.comp_mode);
		r.right = comp_ref(mix_ref(held.right, syn.right, spk, c.speaker_vol, c.synth_mute),
			c.comp_mode);
		return r;
	endfunction

	function automatic mix_ctrl_t make_ctrl(
		input logic [1:0] vol,
		input logic       mute,
		input logic [1:0] mode
	);
		mix_ctrl_t r;

		r.speaker_vol = vol;
		r.synth_mute  = mute;
		r.comp_mode   = comp_mode_t'(mode);
		return r;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	// Drives one tick, then idles so the next tick lands gap cycles later
	task automatic send_sample(
		input stereo_sample_t sb,
		input logic           spk,
		input stereo_sample_t syn,
		input mix_ctrl_t      c,
		input int             gap
	);
		stereo_sample_t exp;

		@(negedge clk_sys);
		sb_sample    = sb;
		speaker      = spk;
		synth_sample = syn;
		ctrl         = c;
		sample_tick  = 1'b1;
		// Agreement is judged on the history before the shift
		if (m_new == m_prev) begin
			m_held = m_prev;
		end
		m_prev = m_new;
		m_new  = sb;
		exp = expected_out(m_held, spk, syn, c);
		exp_q.push_back(exp);
		cyc_q.push_back(cycle_count + 1);
		ticks_sent++;
		repeat (gap - 1) begin
			@(negedge clk_sys);
			sample_tick = 1'b0;
		end
	endtask

	// Same reading for n ticks, random spacing of 3 to 8 cycles
	task automatic send_held(
		input stereo_sample_t sb,
		input logic           spk,
		input stereo_sample_t syn,
		input mix_ctrl_t      c,
		input int             n
	);
		int gap;

		repeat (n) begin
			gap = 3 + ({$random(seed)} % 6);
			send_sample(sb, spk, syn, c, gap);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			sample_tick = 1'b0;
		end
	endtask

	////////////////////
	// Output checker
	////////////////////

	always @(posedge clk_sys) begin
		stereo_sample_t exp;
		int             tick_cyc;

		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles with %0d samples still expected",
				cycle_count, exp_q.size());
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			if (cycle_count >= 2 && ticks_sent == 0 && out_valid !== 1'b0) begin
				$display("[FAIL] %0t out_valid expected 0 actual %b", $time, out_valid);
				error_count++;
			end
			if (out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("At %0t out_valid came with no sample pending", $time);
					error_count++;
				end else begin
					exp = exp_q.pop_front();
					tick_cyc = cyc_q.pop_front();
					if (cycle_count - tick_cyc != 3) begin
						$display("At %0t out_valid came %0d cycles after its tick, not 3",
							$time, cycle_count - tick_cyc);
						error_count++;
					end
					if (out_sample.left !== exp.left) begin
						$display("[FAIL] %0t out_sample.left expected %0d actual %0d",
							$time, exp.left, out_sample.left);
						error_count++;
					end
					if (out_sample.right !== exp.right) begin
						$display("[FAIL] %0t out_sample.right expected %0d actual %0d",
							$time, exp.right, out_sample.right);
						error_count++;
					end
					checks_done++;
				end
			end else if (cyc_q.size() != 0 && cycle_count - cyc_q[0] > 3) begin
				$display("At %0t out_valid missing for the tick of cycle %0d",
					$time, cyc_q[0]);
				void'(exp_q.pop_front());
				void'(cyc_q.pop_front());
				error_count++;
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		stereo_sample_t sb;
		stereo_sample_t syn;
		int             hold;
		int             km;
		int             ks;

		reset        = 1'b1;
		sample_tick  = 1'b0;
		sb_sample    = '0;
		speaker      = 1'b0;
		synth_sample = '0;
		ctrl         = make_ctrl(2'd0, 1'b1, 2'd0);
		m_new        = '0;
		m_prev       = '0;
		m_held       = '0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		idle_cycles(6);

		// Settling filter, single-tick glitches must never pass
		send_held({16'sd1000, -16'sd1000}, 1'b0, '0, make_ctrl(2'd0, 1'b1, 2'd0), 3);
		send_held({16'sd7777, 16'sd7777}, 1'b0, '0, make_ctrl(2'd0, 1'b1, 2'd0), 1);
		send_held({16'sd1000, -16'sd1000}, 1'b0, '0, make_ctrl(2'd0, 1'b1, 2'd0), 3);
		repeat (100) begin
			sb = stereo_sample_t'($random(seed));
			hold = 1 + ({$random(seed)} % 3);
			send_held(sb, 1'b0, '0, make_ctrl(2'd0, 1'b1, 2'd0), hold);
		end

		// Speaker volumes and synth mute, compressor off
		for (int vol = 0; vol < 4; vol++) begin
			for (int mute = 0; mute < 2; mute++) begin
				for (int spk = 0; spk < 2; spk++) begin
					repeat (15) begin
						sb = stereo_sample_t'($random(seed));
						syn = stereo_sample_t'($random(seed));
						send_held(sb, spk[0], syn, make_ctrl(vol[1:0], mute[0], 2'd0), 2);
					end
				end
			end
		end

		// Saturation at both ends
		repeat (20) begin
			sb.left   = pcm_sample_t'(20000 + ({$random(seed)} % 12768));
			sb.right  = pcm_sample_t'(20000 + ({$random(seed)} % 12768));
			syn.left  = pcm_sample_t'(20000 + ({$random(seed)} % 12768));
			syn.right = pcm_sample_t'(20000 + ({$random(seed)} % 12768));
			send_held(sb, 1'b0, syn, make_ctrl(2'd0, 1'b0, 2'd0), 2);
		end
		repeat (20) begin
			sb.left   = pcm_sample_t'(-20000 - int'({$random(seed)} % 12769));
			sb.right  = pcm_sample_t'(-20000 - int'({$random(seed)} % 12769));
			syn.left  = pcm_sample_t'(-20000 - int'({$random(seed)} % 12769));
			syn.right = pcm_sample_t'(-20000 - int'({$random(seed)} % 12769));
			send_held(sb, 1'b0, syn, make_ctrl(2'd0, 1'b0, 2'd0), 2);
		end

		// Compressor curves around both knees and at full scale
		km = knee_point(comp_f_mild, comp_a_mild);
		ks = knee_point(comp_f_strong, comp_a_strong);
		edge_vals = '{0, 1, -1, km - 1, km, km + 1, -km, ks - 1, ks, ks + 1, -ks,
			32767, -32767, -32768, 16384, -16385};
		for (int mode = 1; mode < 4; mode++) begin
			foreach (edge_vals[i]) begin
				sb.left  = pcm_sample_t'(edge_vals[i]);
				sb.right = ~pcm_sample_t'(edge_vals[i]);
				send_held(sb, 1'b0, '0, make_ctrl(2'd0, 1'b1, mode[1:0]), 2);
			end
			repeat (60) begin
				sb = stereo_sample_t'($random(seed));
				send_held(sb, 1'b0, '0, make_ctrl(2'd0, 1'b1, mode[1:0]), 2);
			end
		end

		// Back to back ticks, three samples in flight
		syn = {16'sd1000, -16'sd1500};
		for (int i = 0; i < 64; i++) begin
			if (i % 2 == 0) begin
				sb = stereo_sample_t'($random(seed));
			end
			send_sample(sb, 1'b1, syn, make_ctrl(2'd1, 1'b0, 2'd1), 1);
		end
		idle_cycles(8);

		while (exp_q.size() != 0) begin
			idle_cycles(1);
		end
		idle_cycles(5);

		$display("Checked %0d samples of %0d ticks, %0d errors",
			checks_done, ticks_sent, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- audio_path.f
rtl/audio_sample_pkg.sv
rtl/audio_ctrl_pkg.sv
rtl/sample_settle_filter.sv
rtl/audio_mixer.sv
rtl/dynamic_compressor.sv
rtl/audio_path_top.sv
sim/tb_audio_path.sv

//--- Bender.yml
package:
  name: audio_path

sources:
  - rtl/audio_sample_pkg.sv
  - rtl/audio_ctrl_pkg.sv
  - rtl/sample_settle_filter.sv
  - rtl/audio_mixer.sv
  - rtl/dynamic_compressor.sv
  - rtl/audio_path_top.sv
  - target: simulation
    files:
      - sim/tb_audio_path.sv
